// File: verilog/issue_control_macros.svh
`ifndef ISSUE_CONTROL_MACROS_SVH
`define ISSUE_CONTROL_MACROS_SVH

// Datapath widths fixed by the LC-3b ISA
`define WORD_W 16
`define REG_W 3
`define TAG_W 3  // ROB has 8 entries
`define OPC_W 4

`define NUM_ALU_RS 3

// Opcodes on the issue path
`define OP_ADD 4'd1
`define OP_AND 4'd5
`define OP_NOT 4'd9
`define OP_LDR 4'd6
`define OP_STR 4'd7
`define OP_LEA 4'd14

// Low bit of each instruction field
`define OPC_LSB 12
`define DR_LSB 9   // Also the store source
`define SR1_LSB 6  // Also the load/store base
`define SR2_LSB 0
`define IMM_FLAG 5 // Register or immediate form

`endif

// File: verilog/issue_pkg.sv
`default_nettype none

`include "issue_control_macros.svh"

package issue_pkg;

	typedef logic [`WORD_W-1:0] lc3b_word;
	typedef logic [`REG_W-1:0] lc3b_reg;  // Architectural register
	typedef logic [`TAG_W-1:0] rob_tag;   // ROB entry, doubles as wait tag
	typedef logic [`OPC_W-1:0] lc3b_opcode;

	// Enough bits to number every ALU station
	typedef logic [$clog2(`NUM_ALU_RS)-1:0] rs_id;

	// Where an instruction goes at issue
	typedef enum logic [2:0]
	{
		cls_none,  // Not handled here
		cls_alu,
		cls_load,
		cls_store,
		cls_lea    // ROB only
	} op_class_t;

endpackage

`default_nettype wire

// File: verilog/issue_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "issue_control_macros.svh"

module issue_decode
(
	input issue_pkg::lc3b_word instr,
	output issue_pkg::lc3b_opcode opcode,
	output issue_pkg::op_class_t op_class,
	output issue_pkg::lc3b_reg dest_reg,
	output issue_pkg::lc3b_reg src_a_reg,
	output issue_pkg::lc3b_reg src_b_reg,
	output logic use_imm,
	output issue_pkg::lc3b_word imm5,
	output issue_pkg::lc3b_word mem_offset,
	output issue_pkg::lc3b_word pc_offset
);

	import issue_pkg::*;

	assign opcode = instr[`OPC_LSB +: `OPC_W];

	always_comb
	begin
		case (opcode)
			`OP_ADD, `OP_AND, `OP_NOT: op_class = cls_alu;
			`OP_LDR: op_class = cls_load;
			`OP_STR: op_class = cls_store;
			`OP_LEA: op_class = cls_lea;
			default: op_class = cls_none; // Issues nothing
		endcase
	end

	assign dest_reg = instr[`DR_LSB +: `REG_W];
	assign src_a_reg = instr[`SR1_LSB +: `REG_W];

	// Store data register sits in the DR field
	assign src_b_reg = (op_class == cls_store) ? instr[`DR_LSB +: `REG_W]
		: instr[`SR2_LSB +: `REG_W];

	// NOT has no register form
	assign use_imm = (op_class == cls_alu) && (instr[`IMM_FLAG] || (opcode == `OP_NOT));

	assign imm5 = {{(`WORD_W-5){instr[4]}}, instr[4:0]};

	// Word-scaled offsets
	assign mem_offset = {{(`WORD_W-7){instr[5]}}, instr[5:0], 1'b0};
	assign pc_offset = {{(`WORD_W-10){instr[8]}}, instr[8:0], 1'b0};

endmodule

`default_nettype wire

// File: verilog/operand_forward.sv
`timescale 1ns/1ns
`default_nettype none

module operand_forward
(
	input logic reg_busy,
	input issue_pkg::lc3b_word reg_data,
	input issue_pkg::rob_tag reg_entry,
	input logic cdb_valid,
	input issue_pkg::rob_tag cdb_tag,
	input issue_pkg::lc3b_word cdb_data,
	input logic rob_valid,
	input issue_pkg::lc3b_word rob_value,
	output issue_pkg::lc3b_word value,
	output logic value_valid,
	output issue_pkg::rob_tag wait_tag
);

	import issue_pkg::*;

	logic cdb_hit;

	assign cdb_hit = cdb_valid && (cdb_tag == reg_entry); // Producer broadcasting now

	always_comb
	begin
		value = reg_data;
		value_valid = 1'b1;
		wait_tag = '0;
		if (reg_busy)
		begin
			if (cdb_hit)
				value = cdb_data;
			else if (rob_valid)
				value = rob_value; // Done but not yet committed
			else
			begin
				value = '0;
				value_valid = 1'b0;
				wait_tag = reg_entry; // Station snoops the CDB for this
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/issue_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

`include "issue_control_macros.svh"

module issue_dispatch
(
	input logic clk,
	input logic rst_n,
	input logic instr_is_new,
	input issue_pkg::lc3b_opcode opcode,
	input issue_pkg::op_class_t op_class,
	input issue_pkg::lc3b_reg dest_reg,
	input logic use_imm,
	input issue_pkg::lc3b_word imm5,
	input issue_pkg::lc3b_word mem_offset,
	input issue_pkg::lc3b_word pc_offset,
	input issue_pkg::lc3b_word curr_pc,
	input issue_pkg::lc3b_word a_value,
	input logic a_valid,
	input issue_pkg::rob_tag a_tag,
	input issue_pkg::lc3b_word b_value,
	input logic b_valid,
	input issue_pkg::rob_tag b_tag,
	input logic [`NUM_ALU_RS-1:0] alu_rs_busy,
	input logic ldstr_full,
	input logic rob_full,
	input issue_pkg::rob_tag rob_addr,
	output logic stall,
	output logic res_write,
	output issue_pkg::rs_id res_station_id,
	output issue_pkg::lc3b_opcode res_op,
	output issue_pkg::lc3b_word res_vj,
	output logic res_vj_valid,
	output issue_pkg::rob_tag res_qj,
	output issue_pkg::lc3b_word res_vk,
	output logic res_vk_valid,
	output issue_pkg::rob_tag res_qk,
	output issue_pkg::rob_tag res_dest,
	output logic ldstr_write,
	output issue_pkg::lc3b_opcode ldstr_op,
	output issue_pkg::lc3b_word ldstr_offset,
	output issue_pkg::lc3b_word ldstr_vbase,
	output logic ldstr_vbase_valid,
	output issue_pkg::rob_tag ldstr_qbase,
	output issue_pkg::lc3b_word ldstr_vsrc,
	output logic ldstr_vsrc_valid,
	output issue_pkg::rob_tag ldstr_qsrc,
	output issue_pkg::rob_tag ldstr_dest,
	output logic rob_write,
	output issue_pkg::lc3b_opcode rob_op,
	output issue_pkg::lc3b_reg rob_dest,
	output issue_pkg::lc3b_word rob_value,
	output logic reg_busy_write,
	output issue_pkg::lc3b_reg reg_dest,
	output issue_pkg::rob_tag reg_rob_entry
);

	import issue_pkg::*;

	logic is_alu;
	logic is_ldst;
	logic is_store;
	logic writes_reg;
	logic issue;
	rs_id free_id;

	assign is_alu = (op_class == cls_alu);
	assign is_store = (op_class == cls_store);
	assign is_ldst = (op_class == cls_load) || is_store;
	assign writes_reg = is_alu || (op_class == cls_load) || (op_class == cls_lea);

	// Unhandled opcodes never hold up fetch
	assign stall = instr_is_new && (op_class != cls_none) && (rob_full
		|| (is_alu && (&alu_rs_busy))
		|| (is_ldst && ldstr_full));

	assign issue = instr_is_new && !stall;

	// Lowest numbered free station wins
	always_comb
	begin
		free_id = '0;
		for (int i = `NUM_ALU_RS-1; i >= 0; i--)
		begin
			if (!alu_rs_busy[i])
				free_id = rs_id'(i);
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			res_write <= 1'b0;
			ldstr_write <= 1'b0;
			rob_write <= 1'b0;
			reg_busy_write <= 1'b0;
			res_station_id <= '0;
			res_op <= '0;
			res_vj <= '0;
			res_vj_valid <= 1'b0;
			res_qj <= '0;
			res_vk <= '0;
			res_vk_valid <= 1'b0;
			res_qk <= '0;
			res_dest <= '0;
			ldstr_op <= '0;
			ldstr_offset <= '0;
			ldstr_vbase <= '0;
			ldstr_vbase_valid <= 1'b0;
			ldstr_qbase <= '0;
			ldstr_vsrc <= '0;
			ldstr_vsrc_valid <= 1'b0;
			ldstr_qsrc <= '0;
			ldstr_dest <= '0;
			rob_op <= '0;
			rob_dest <= '0;
			rob_value <= '0;
			reg_dest <= '0;
			reg_rob_entry <= '0;
		end
		else
		begin
			// One-cycle write pulses
			res_write <= issue && is_alu;
			ldstr_write <= issue && is_ldst;
			rob_write <= issue && (op_class != cls_none);
			reg_busy_write <= issue && writes_reg;
			if (issue)
			begin
				res_station_id <= free_id;
				res_op <= opcode;
				res_vj <= a_value;
				res_vj_valid <= a_valid;
				res_qj <= a_tag;
				res_vk <= use_imm ? imm5 : b_value;
				res_vk_valid <= use_imm || b_valid;
				res_qk <= use_imm ? '0 : b_tag;
				res_dest <= rob_addr;
				ldstr_op <= opcode;
				ldstr_offset <= mem_offset;
				ldstr_vbase <= a_value; // Base always from SR1 field
				ldstr_vbase_valid <= a_valid;
				ldstr_qbase <= a_tag;
				ldstr_vsrc <= is_store ? b_value : '0;
				ldstr_vsrc_valid <= is_store ? b_valid : 1'b1; // Loads have no data
				ldstr_qsrc <= is_store ? b_tag : '0;
				ldstr_dest <= is_store ? '0 : rob_addr;
				rob_op <= opcode;
				rob_dest <= is_store ? '0 : dest_reg;
				rob_value <= (op_class == cls_lea) ? (curr_pc + pc_offset) : '0;
				reg_dest <= dest_reg;
				reg_rob_entry <= rob_addr;
			end
		end
	end

	// Picked station has to be one the status reports free
	assert property (@(posedge clk) disable iff (!rst_n)
		(issue && is_alu) |-> !alu_rs_busy[free_id])
		else $error("issue_dispatch: ALU op sent to a busy station");

	// Fetch holds the instruction while stalled
	assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> instr_is_new && $stable({opcode, dest_reg, pc_offset}))
		else $error("issue_dispatch: instruction changed during a stall");

endmodule

`default_nettype wire

// File: verilog/issue_control.sv
`timescale 1ns/1ns
`default_nettype none

`include "issue_control_macros.svh"

module issue_control
(
	input logic clk,
	input logic rst_n,
	input issue_pkg::lc3b_word instr,
	input logic instr_is_new,
	input issue_pkg::lc3b_word curr_pc,
	output logic stall,
	input logic cdb_valid,
	input issue_pkg::rob_tag cdb_tag,
	input issue_pkg::lc3b_word cdb_data,
	input logic [`NUM_ALU_RS-1:0] alu_rs_busy,
	input logic ldstr_full,
	input logic rob_full,
	input issue_pkg::rob_tag rob_addr,
	input logic rob_a_valid,
	input issue_pkg::lc3b_word rob_a_value,
	input logic rob_b_valid,
	input issue_pkg::lc3b_word rob_b_value,
	output issue_pkg::rob_tag rob_a_addr,
	output issue_pkg::rob_tag rob_b_addr,
	output issue_pkg::lc3b_reg src_a_reg,
	output issue_pkg::lc3b_reg src_b_reg,
	input logic reg_a_busy,
	input issue_pkg::lc3b_word reg_a_data,
	input issue_pkg::rob_tag reg_a_entry,
	input logic reg_b_busy,
	input issue_pkg::lc3b_word reg_b_data,
	input issue_pkg::rob_tag reg_b_entry,
	output logic res_write,
	output issue_pkg::rs_id res_station_id,
	output issue_pkg::lc3b_opcode res_op,
	output issue_pkg::lc3b_word res_vj,
	output logic res_vj_valid,
	output issue_pkg::rob_tag res_qj,
	output issue_pkg::lc3b_word res_vk,
	output logic res_vk_valid,
	output issue_pkg::rob_tag res_qk,
	output issue_pkg::rob_tag res_dest,
	output logic ldstr_write,
	output issue_pkg::lc3b_opcode ldstr_op,
	output issue_pkg::lc3b_word ldstr_offset,
	output issue_pkg::lc3b_word ldstr_vbase,
	output logic ldstr_vbase_valid,
	output issue_pkg::rob_tag ldstr_qbase,
	output issue_pkg::lc3b_word ldstr_vsrc,
	output logic ldstr_vsrc_valid,
	output issue_pkg::rob_tag ldstr_qsrc,
	output issue_pkg::rob_tag ldstr_dest,
	output logic rob_write,
	output issue_pkg::lc3b_opcode rob_op,
	output issue_pkg::lc3b_reg rob_dest,
	output issue_pkg::lc3b_word rob_value,
	output logic reg_busy_write,
	output issue_pkg::lc3b_reg reg_dest,
	output issue_pkg::rob_tag reg_rob_entry
);

	import issue_pkg::*;

	lc3b_opcode opcode;
	op_class_t op_class;
	lc3b_reg dest_reg;
	logic use_imm;
	lc3b_word imm5;
	lc3b_word mem_offset;
	lc3b_word pc_offset;
	lc3b_word a_value;
	logic a_valid;
	rob_tag a_tag;
	lc3b_word b_value;
	logic b_valid;
	rob_tag b_tag;

	// ROB is read at the producer entry the register file reports
	assign rob_a_addr = reg_a_entry;
	assign rob_b_addr = reg_b_entry;

	issue_decode u_decode
	(
		.instr(instr),
		.opcode(opcode),
		.op_class(op_class),
		.dest_reg(dest_reg),
		.src_a_reg(src_a_reg),
		.src_b_reg(src_b_reg),
		.use_imm(use_imm),
		.imm5(imm5),
		.mem_offset(mem_offset),
		.pc_offset(pc_offset)
	);

	operand_forward u_fwd_a // j operand or base
	(
		.reg_busy(reg_a_busy),
		.reg_data(reg_a_data),
		.reg_entry(reg_a_entry),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data),
		.rob_valid(rob_a_valid),
		.rob_value(rob_a_value),
		.value(a_value),
		.value_valid(a_valid),
		.wait_tag(a_tag)
	);

	operand_forward u_fwd_b // k operand or store data
	(
		.reg_busy(reg_b_busy),
		.reg_data(reg_b_data),
		.reg_entry(reg_b_entry),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data),
		.rob_valid(rob_b_valid),
		.rob_value(rob_b_value),
		.value(b_value),
		.value_valid(b_valid),
		.wait_tag(b_tag)
	);

	issue_dispatch u_dispatch
	(
		.clk(clk),
		.rst_n(rst_n),
		.instr_is_new(instr_is_new),
		.opcode(opcode),
		.op_class(op_class),
		.dest_reg(dest_reg),
		.use_imm(use_imm),
		.imm5(imm5),
		.mem_offset(mem_offset),
		.pc_offset(pc_offset),
		.curr_pc(curr_pc),
		.a_value(a_value),
		.a_valid(a_valid),
		.a_tag(a_tag),
		.b_value(b_value),
		.b_valid(b_valid),
		.b_tag(b_tag),
		.alu_rs_busy(alu_rs_busy),
		.ldstr_full(ldstr_full),
		.rob_full(rob_full),
		.rob_addr(rob_addr),
		.stall(stall),
		.res_write(res_write),
		.res_station_id(res_station_id),
		.res_op(res_op),
		.res_vj(res_vj),
		.res_vj_valid(res_vj_valid),
		.res_qj(res_qj),
		.res_vk(res_vk),
		.res_vk_valid(res_vk_valid),
		.res_qk(res_qk),
		.res_dest(res_dest),
		.ldstr_write(ldstr_write),
		.ldstr_op(ldstr_op),
		.ldstr_offset(ldstr_offset),
		.ldstr_vbase(ldstr_vbase),
		.ldstr_vbase_valid(ldstr_vbase_valid),
		.ldstr_qbase(ldstr_qbase),
		.ldstr_vsrc(ldstr_vsrc),
		.ldstr_vsrc_valid(ldstr_vsrc_valid),
		.ldstr_qsrc(ldstr_qsrc),
		.ldstr_dest(ldstr_dest),
		.rob_write(rob_write),
		.rob_op(rob_op),
		.rob_dest(rob_dest),
		.rob_value(rob_value),
		.reg_busy_write(reg_busy_write),
		.reg_dest(reg_dest),
		.reg_rob_entry(reg_rob_entry)
	);

endmodule

`default_nettype wire

// File: verification/tb_issue_control.sv
`timescale 1ns/1ns
`default_nettype none

`include "issue_control_macros.svh"

module tb_issue_control;

	logic clk;
	logic rst_n;
	logic [15:0] instr;
	logic instr_is_new;
	logic [15:0] curr_pc;
	logic stall;
	logic cdb_valid;
	logic [2:0] cdb_tag;
	logic [15:0] cdb_data;
	logic [2:0] alu_rs_busy;
	logic ldstr_full;
	logic rob_full;
	logic [2:0] rob_addr;
	logic rob_a_valid;
	logic [15:0] rob_a_value;
	logic rob_b_valid;
	logic [15:0] rob_b_value;
	logic [2:0] rob_a_addr;
	logic [2:0] rob_b_addr;
	logic [2:0] src_a_reg;
	logic [2:0] src_b_reg;
	logic reg_a_busy;
	logic [15:0] reg_a_data;
	logic [2:0] reg_a_entry;
	logic reg_b_busy;
	logic [15:0] reg_b_data;
	logic [2:0] reg_b_entry;
	logic res_write;
	logic [1:0] res_station_id;
	logic [3:0] res_op;
	logic [15:0] res_vj;
	logic res_vj_valid;
	logic [2:0] res_qj;
	logic [15:0] res_vk;
	logic res_vk_valid;
	logic [2:0] res_qk;
	logic [2:0] res_dest;
	logic ldstr_write;
	logic [3:0] ldstr_op;
	logic [15:0] ldstr_offset;
	logic [15:0] ldstr_vbase;
	logic ldstr_vbase_valid;
	logic [2:0] ldstr_qbase;
	logic [15:0] ldstr_vsrc;
	logic ldstr_vsrc_valid;
	logic [2:0] ldstr_qsrc;
	logic [2:0] ldstr_dest;
	logic rob_write;
	logic [3:0] rob_op;
	logic [2:0] rob_dest;
	logic [15:0] rob_value;
	logic reg_busy_write;
	logic [2:0] reg_dest;
	logic [2:0] reg_rob_entry;

	int errors;
	int checks;
	logic [31:0] lfsr_state;

	issue_control u_issue_control (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v[i] = lfsr_state[0];
		end
	endtask

	function automatic logic [15:0] sign_extend(input logic [15:0] v, input int width);
		logic [15:0] r;
		r = v;
		for (int i = width; i < 16; i++)
			r[i] = v[width-1];
		return r;
	endfunction

	function automatic int lowest_free(input logic [2:0] busy);
		for (int i = 0; i < 3; i++)
			if (!busy[i])
				return i;
		return 0;
	endfunction

	function automatic logic [15:0] encode_reg(input logic [3:0] opc, input logic [2:0] dr,
		input logic [2:0] sr1, input logic [2:0] sr2);
		return {opc, dr, sr1, 3'b000, sr2};
	endfunction

	function automatic logic [15:0] encode_imm(input logic [3:0] opc, input logic [2:0] dr,
		input logic [2:0] sr1, input logic [4:0] imm);
		return {opc, dr, sr1, 1'b1, imm};
	endfunction

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_no_writes();
		check_value("res_write", res_write, 0);
		check_value("ldstr_write", ldstr_write, 0);
		check_value("rob_write", rob_write, 0);
		check_value("reg_busy_write", reg_busy_write, 0);
	endtask

	task automatic set_idle();
		instr = '0;
		instr_is_new = 1'b0;
		curr_pc = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		alu_rs_busy = '0;
		ldstr_full = 1'b0;
		rob_full = 1'b0;
		rob_addr = '0;
		rob_a_valid = 1'b0;
		rob_a_value = '0;
		rob_b_valid = 1'b0;
		rob_b_value = '0;
		reg_a_busy = 1'b0;
		reg_a_data = '0;
		reg_a_entry = '0;
		reg_b_busy = 1'b0;
		reg_b_data = '0;
		reg_b_entry = '0;
	endtask

	// Returns 1 ns after the edge that carries the ROB write pulse
	task automatic wait_for_issue();
		int n;
		n = 0;
		@(posedge clk);
		#1;
		while (!rob_write && n < 20)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!rob_write)
		begin
			errors++;
			$display("Timeout at %0t ns: instruction never issued", $time);
		end
	endtask

	// Retire the instruction and confirm the pulse lasted one cycle
	task automatic end_issue();
		#1;
		instr_is_new = 1'b0;
		@(posedge clk);
		#1;
		check_no_writes();
		#1;
		set_idle();
	endtask

	task automatic test_reset_idle();
		instr = encode_reg(`OP_ADD, 3'd1, 3'd2, 3'd3);
		repeat (3)
		begin
			@(posedge clk);
			#1;
			check_value("stall", stall, 0);
			check_no_writes();
		end
		#1;
		instr = 16'h0e05; // BR, not on the issue path
		instr_is_new = 1'b1;
		rob_full = 1'b1;
		@(posedge clk);
		#1;
		check_value("stall", stall, 0);
		check_no_writes();
		#1;
		set_idle();
	endtask

	task automatic test_add_reg();
		logic [15:0] a_data;
		logic [15:0] b_data;
		logic [2:0] busy_pat [3];
		busy_pat = '{3'b000, 3'b101, 3'b011};
		for (int t = 0; t < 3; t++)
		begin
			take_bits(16, a_data);
			take_bits(16, b_data);
			alu_rs_busy = busy_pat[t];
			reg_a_data = a_data;
			reg_b_data = b_data;
			rob_addr = 3'(t + 2);
			instr = encode_reg(`OP_ADD, 3'd3, 3'd1, 3'd5);
			instr_is_new = 1'b1;
			#1;
			check_value("src_a_reg", src_a_reg, 1);
			check_value("src_b_reg", src_b_reg, 5);
			wait_for_issue();
			check_value("res_write", res_write, 1);
			check_value("res_vj", res_vj, a_data);
			check_value("res_vj_valid", res_vj_valid, 1);
			check_value("res_vk", res_vk, b_data);
			check_value("res_vk_valid", res_vk_valid, 1);
			check_value("res_station_id", res_station_id, lowest_free(busy_pat[t]));
			check_value("res_op", res_op, `OP_ADD);
			check_value("res_dest", res_dest, t + 2);
			check_value("rob_dest", rob_dest, 3);
			check_value("reg_dest", reg_dest, 3);
			check_value("reg_rob_entry", reg_rob_entry, t + 2);
			check_value("reg_busy_write", reg_busy_write, 1);
			check_value("ldstr_write", ldstr_write, 0);
			end_issue();
		end
	endtask

	task automatic test_forwarding();
		logic [15:0] d0;
		logic [15:0] d1;
		logic [15:0] imm;
		take_bits(16, d0);
		take_bits(16, d1);
		// CDB beats ROB on a, ROB alone on b
		reg_a_busy = 1'b1;
		reg_a_entry = 3'd4;
		reg_b_busy = 1'b1;
		reg_b_entry = 3'd2;
		cdb_valid = 1'b1;
		cdb_tag = 3'd4;
		cdb_data = d0;
		rob_a_valid = 1'b1;
		rob_a_value = ~d0;
		rob_b_valid = 1'b1;
		rob_b_value = d1;
		instr = encode_reg(`OP_ADD, 3'd0, 3'd2, 3'd7);
		instr_is_new = 1'b1;
		#1;
		check_value("rob_a_addr", rob_a_addr, 4);
		check_value("rob_b_addr", rob_b_addr, 2);
		wait_for_issue();
		check_value("res_vj", res_vj, d0);
		check_value("res_vj_valid", res_vj_valid, 1);
		check_value("res_vk", res_vk, d1);
		check_value("res_vk_valid", res_vk_valid, 1);
		end_issue();
		// Nothing to forward on a, so it waits on the tag
		reg_a_busy = 1'b1;
		reg_a_entry = 3'd6;
		cdb_valid = 1'b1;
		cdb_tag = 3'd3;
		reg_b_data = d1;
		instr = encode_reg(`OP_ADD, 3'd1, 3'd4, 3'd2);
		instr_is_new = 1'b1;
		wait_for_issue();
		check_value("res_vj_valid", res_vj_valid, 0);
		check_value("res_qj", res_qj, 6);
		check_value("res_vk", res_vk, d1);
		end_issue();
		take_bits(5, imm);
		reg_b_busy = 1'b1; // Ignored in immediate form
		reg_b_entry = 3'd5;
		instr = encode_imm(`OP_AND, 3'd2, 3'd3, imm[4:0]);
		instr_is_new = 1'b1;
		wait_for_issue();
		check_value("res_vk", res_vk, sign_extend(imm, 5));
		check_value("res_vk_valid", res_vk_valid, 1);
		check_value("res_qk", res_qk, 0);
		end_issue();
		instr = {`OP_NOT, 3'd5, 3'd6, 6'b111111};
		instr_is_new = 1'b1;
		wait_for_issue();
		check_value("res_op", res_op, `OP_NOT);
		check_value("res_vk", res_vk, 16'hffff);
		check_value("res_vk_valid", res_vk_valid, 1);
		end_issue();
	endtask

	task automatic test_load_store();
		logic [15:0] off;
		logic [15:0] base;
		logic [15:0] src;
		take_bits(6, off);
		take_bits(16, base);
		reg_a_data = base;
		rob_addr = 3'd6;
		instr = {`OP_LDR, 3'd2, 3'd3, off[5:0]};
		instr_is_new = 1'b1;
		wait_for_issue();
		check_value("ldstr_write", ldstr_write, 1);
		check_value("res_write", res_write, 0);
		check_value("ldstr_op", ldstr_op, `OP_LDR);
		check_value("ldstr_offset", ldstr_offset, sign_extend(off, 6) << 1);
		check_value("ldstr_vbase", ldstr_vbase, base);
		check_value("ldstr_vbase_valid", ldstr_vbase_valid, 1);
		check_value("ldstr_qbase", ldstr_qbase, 0);
		check_value("ldstr_dest", ldstr_dest, 6);
		check_value("rob_dest", rob_dest, 2);
		check_value("reg_busy_write", reg_busy_write, 1);
		end_issue();
		take_bits(6, off);
		take_bits(16, src);
		reg_b_data = src;
		reg_a_busy = 1'b1; // Base still in flight
		reg_a_entry = 3'd5;
		rob_addr = 3'd1;
		instr = {`OP_STR, 3'd6, 3'd1, off[5:0]};
		instr_is_new = 1'b1;
		#1;
		check_value("src_b_reg", src_b_reg, 6);
		wait_for_issue();
		check_value("ldstr_write", ldstr_write, 1);
		check_value("ldstr_offset", ldstr_offset, sign_extend(off, 6) << 1);
		check_value("ldstr_vbase_valid", ldstr_vbase_valid, 0);
		check_value("ldstr_qbase", ldstr_qbase, 5);
		check_value("ldstr_vsrc", ldstr_vsrc, src);
		check_value("ldstr_vsrc_valid", ldstr_vsrc_valid, 1);
		check_value("ldstr_qsrc", ldstr_qsrc, 0);
		check_value("ldstr_dest", ldstr_dest, 0);
		check_value("rob_op", rob_op, `OP_STR);
		check_value("rob_dest", rob_dest, 0);
		check_value("reg_busy_write", reg_busy_write, 0);
		end_issue();
	endtask

	task automatic test_lea();
		logic [15:0] pc;
		logic [15:0] off;
		take_bits(16, pc);
		take_bits(9, off);
		curr_pc = pc;
		rob_addr = 3'd3;
		instr = {`OP_LEA, 3'd4, off[8:0]};
		instr_is_new = 1'b1;
		wait_for_issue();
		check_value("rob_value", rob_value, pc + (sign_extend(off, 9) << 1));
		check_value("rob_op", rob_op, `OP_LEA);
		check_value("rob_dest", rob_dest, 4);
		check_value("res_write", res_write, 0);
		check_value("ldstr_write", ldstr_write, 0);
		check_value("reg_busy_write", reg_busy_write, 1);
		check_value("reg_rob_entry", reg_rob_entry, 3);
		end_issue();
	endtask

	// 0 full ROB, 1 all ALU stations busy, 2 full load/store buffer
	task automatic stall_case(input int kind);
		case (kind)
			0: rob_full = 1'b1;
			1: alu_rs_busy = 3'b111;
			default: ldstr_full = 1'b1;
		endcase
		instr = (kind == 2) ? {`OP_LDR, 3'd1, 3'd2, 6'd4} : encode_reg(`OP_ADD, 3'd1, 3'd2, 3'd3);
		instr_is_new = 1'b1;
		#1;
		check_value("stall", stall, 1);
		repeat (3)
		begin
			@(posedge clk);
			#1;
			check_value("stall", stall, 1);
			check_no_writes();
		end
		#1;
		rob_full = 1'b0;
		alu_rs_busy = '0;
		ldstr_full = 1'b0;
		wait_for_issue();
		check_value("res_write", res_write, kind != 2);
		check_value("ldstr_write", ldstr_write, kind == 2);
		end_issue();
	endtask

	initial
	begin
		errors = 0;
		checks = 0;
		lfsr_state = 32'h8311a98b;
		set_idle();
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;
		test_reset_idle();
		test_add_reg();
		test_forwarding();
		test_load_store();
		test_lea();
		for (int k = 0; k < 3; k++)
			stall_case(k);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: issue_control.f
+incdir+verilog
verilog/issue_pkg.sv
verilog/issue_decode.sv
verilog/operand_forward.sv
verilog/issue_dispatch.sv
verilog/issue_control.sv
verification/tb_issue_control.sv
